// ==== rtl/cpu_pkg.sv ====
// cpu shared definitions
`default_nettype none

package cpu_pkg;

    // word widths
    localparam int WORD_W = 16;
    localparam int REG_W  = 8;

    // instruction fields: [15:12] rsel, [11:8] opcode, [7:0] immediate
    localparam int IMM_LSB  = 0;
    localparam int IMM_W    = 8;
    localparam int OP_LSB   = 8;
    localparam int OP_W     = 4;
    localparam int RSEL_LSB = 12;
    localparam int RSEL_W   = 4;

    typedef enum logic [OP_W-1:0] {
        OP_NOP    = 4'd0,
        OP_OUTI   = 4'd1,
        OP_OUTLOC = 4'd2,
        OP_LI     = 4'd3,
        OP_OUTR   = 4'd4,
        OP_HALT   = 4'd15
    } op_e;

    // apb byte offsets
    localparam logic [7:0] REG_CTRL    = 8'h00;
    localparam logic [7:0] REG_STATUS  = 8'h04;
    localparam logic [7:0] REG_LD_ADDR = 8'h08;
    localparam logic [7:0] REG_LD_DATA = 8'h0C;
    localparam logic [7:0] REG_OUT_CNT = 8'h10;

endpackage

`default_nettype wire

// ==== rtl/cpu_regfile.sv ====
// general register file
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile import cpu_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire              we,
    input  wire [RSEL_W-1:0] waddr,
    input  wire [REG_W-1:0]  wdata,
    input  wire [RSEL_W-1:0] raddr,
    output logic [REG_W-1:0] rdata
);

    logic [REG_W-1:0] regs [2**RSEL_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**RSEL_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // read port is asynchronous
    assign rdata = regs[raddr];

endmodule

`default_nettype wire

// ==== rtl/prog_mem.sv ====
// program memory
`timescale 1ns/1ps
`default_nettype none

module prog_mem import cpu_pkg::*; #(
    parameter int MEM_AW = 8
) (
    input  wire               clk,
    input  wire               wr_en,
    input  wire [MEM_AW-1:0]  wr_addr,
    input  wire [WORD_W-1:0]  wr_data,
    input  wire [MEM_AW-1:0]  rd_addr,
    output logic [WORD_W-1:0] rd_data
);

    logic [WORD_W-1:0] mem [2**MEM_AW];

    // load port from the register block
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, same-address write gives the old word
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_core.sv ====
// cpu sequencer
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; #(
    parameter int MEM_AW = 8
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               start,
    output logic              running,
    output logic [MEM_AW-1:0] mem_addr,
    input  wire [WORD_W-1:0]  mem_data,
    output logic              rf_we,
    output logic [RSEL_W-1:0] rf_waddr,
    output logic [REG_W-1:0]  rf_wdata,
    output logic [RSEL_W-1:0] rf_raddr,
    input  wire [REG_W-1:0]   rf_rdata,
    output logic [WORD_W-1:0] out_data,
    output logic              out_valid
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ISSUE,
        S_DECODE,
        S_EXEC,
        S_LOAD_ISSUE,
        S_LOAD_WAIT
    } state_e;

    localparam logic [MEM_AW-1:0] PC_ONE = {{(MEM_AW-1){1'b0}}, 1'b1};

    state_e             state;
    logic [MEM_AW-1:0]  pc;
    op_e                op_q;
    logic [RSEL_W-1:0]  rsel_q;
    logic [IMM_W-1:0]   imm_q;
    logic [IMM_W-1:0]   imm_shr;
    logic [MEM_AW+IMM_W-1:0] data_addr;

    // outloc address, widened then cut to the memory size
    assign imm_shr   = imm_q >> 1;
    assign data_addr = {{MEM_AW{1'b0}}, imm_shr};

    assign mem_addr = (state == S_LOAD_ISSUE) ? data_addr[MEM_AW-1:0] : pc;

    // register file hookup
    assign rf_we    = (state == S_EXEC) && (op_q == OP_LI);
    assign rf_waddr = rsel_q;
    assign rf_wdata = imm_q;
    assign rf_raddr = rsel_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            pc        <= '0;
            running   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        pc      <= '0;
                        running <= 1'b1;
                        state   <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    state <= S_DECODE;
                end
                S_DECODE: begin
                    state <= S_EXEC;
                end
                S_EXEC: begin
                    // pc wraps at the end of memory
                    pc    <= pc + PC_ONE;
                    state <= S_ISSUE;
                    case (op_q)
                        OP_OUTI, OP_OUTR: out_valid <= 1'b1;
                        OP_OUTLOC: state <= S_LOAD_ISSUE;
                        OP_HALT: begin
                            running <= 1'b0;
                            state   <= S_IDLE;
                        end
                        default: ;
                    endcase
                end
                S_LOAD_ISSUE: begin
                    state <= S_LOAD_WAIT;
                end
                S_LOAD_WAIT: begin
                    out_valid <= 1'b1;
                    state     <= S_ISSUE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // instruction fields and output word
    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            op_q   <= op_e'(mem_data[OP_LSB +: OP_W]);
            rsel_q <= mem_data[RSEL_LSB +: RSEL_W];
            imm_q  <= mem_data[IMM_LSB +: IMM_W];
        end
        if (state == S_EXEC) begin
            if (op_q == OP_OUTI) begin
                out_data <= {{(WORD_W-IMM_W){1'b0}}, imm_q};
            end else if (op_q == OP_OUTR) begin
                out_data <= {{(WORD_W-REG_W){1'b0}}, rf_rdata};
            end
        end else if (state == S_LOAD_WAIT) begin
            out_data <= mem_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_ctrl_regs.sv ====
// apb control registers
`timescale 1ns/1ps
`default_nettype none

module cpu_ctrl_regs import cpu_pkg::*; #(
    parameter int MEM_AW = 8
) (
    input  wire               clk,
    input  wire               rst,
    input  wire [7:0]         paddr,
    input  wire               psel,
    input  wire               penable,
    input  wire               pwrite,
    input  wire [31:0]        pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    input  wire               running,
    input  wire               out_valid,
    output logic              start,
    output logic              ld_we,
    output logic [MEM_AW-1:0] ld_addr,
    output logic [WORD_W-1:0] ld_data
);

    localparam logic [MEM_AW-1:0] ADDR_ONE = {{(MEM_AW-1){1'b0}}, 1'b1};

    logic        access;
    logic        wr_access;
    logic        mapped;
    logic        ld_sel;
    logic        ran_q;
    logic [31:0] out_cnt;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign mapped    = (paddr == REG_CTRL) || (paddr == REG_STATUS) ||
                       (paddr == REG_LD_ADDR) || (paddr == REG_LD_DATA) ||
                       (paddr == REG_OUT_CNT);
    assign ld_sel    = (paddr == REG_LD_ADDR) || (paddr == REG_LD_DATA);

    // zero wait states
    assign pready  = 1'b1;
    assign pslverr = access && (!mapped || (pwrite && running && ld_sel));

    // memory load port, blocked while the core runs
    assign ld_we   = wr_access && (paddr == REG_LD_DATA) && !running;
    assign ld_data = pwdata[WORD_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start   <= 1'b0;
            ld_addr <= '0;
            ran_q   <= 1'b0;
            out_cnt <= '0;
        end else begin
            start <= wr_access && (paddr == REG_CTRL) && pwdata[0] && !running;
            if (wr_access && (paddr == REG_LD_ADDR) && !running) begin
                ld_addr <= pwdata[MEM_AW-1:0];
            end else if (ld_we) begin
                ld_addr <= ld_addr + ADDR_ONE;
            end
            // halted-after-run needs running to have been seen
            if (start) begin
                ran_q <= 1'b0;
            end else if (running) begin
                ran_q <= 1'b1;
            end
            if (start) begin
                out_cnt <= '0;
            end else if (out_valid) begin
                out_cnt <= out_cnt + 32'd1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_STATUS:  prdata = {30'd0, ran_q && !running, running};
            REG_LD_ADDR: prdata = {{(32-MEM_AW){1'b0}}, ld_addr};
            REG_OUT_CNT: prdata = out_cnt;
            default:     prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
// cpu subsystem top
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter int MEM_AW = 8
) (
    input  wire               clk,
    input  wire               rst,
    input  wire [7:0]         paddr,
    input  wire               psel,
    input  wire               penable,
    input  wire               pwrite,
    input  wire [31:0]        pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output logic [WORD_W-1:0] out_data,
    output logic              out_valid
);

    logic              start;
    logic              running;
    logic              ld_we;
    logic [MEM_AW-1:0] ld_addr;
    logic [WORD_W-1:0] ld_data;
    logic [MEM_AW-1:0] mem_addr;
    logic [WORD_W-1:0] mem_data;
    logic              rf_we;
    logic [RSEL_W-1:0] rf_waddr;
    logic [REG_W-1:0]  rf_wdata;
    logic [RSEL_W-1:0] rf_raddr;
    logic [REG_W-1:0]  rf_rdata;

    cpu_ctrl_regs #(.MEM_AW(MEM_AW)) i_ctrl (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .running(running), .out_valid(out_valid), .start(start),
        .ld_we(ld_we), .ld_addr(ld_addr), .ld_data(ld_data)
    );

    cpu_core #(.MEM_AW(MEM_AW)) i_core (
        .clk(clk), .rst(rst), .start(start), .running(running),
        .mem_addr(mem_addr), .mem_data(mem_data),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .rf_raddr(rf_raddr), .rf_rdata(rf_rdata),
        .out_data(out_data), .out_valid(out_valid)
    );

    cpu_regfile i_regfile (
        .clk(clk), .rst(rst), .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .raddr(rf_raddr), .rdata(rf_rdata)
    );

    prog_mem #(.MEM_AW(MEM_AW)) i_mem (
        .clk(clk), .wr_en(ld_we), .wr_addr(ld_addr), .wr_data(ld_data),
        .rd_addr(mem_addr), .rd_data(mem_data)
    );

endmodule

`default_nettype wire

// ==== tb/cpu_props.sv ====
// handshake assertions
`timescale 1ns/1ps
`default_nettype none

module cpu_props (
    input wire clk,
    input wire rst,
    input wire pready,
    input wire out_valid,
    input wire running
);

    // one pulse per emitted word
    a_valid_pulse: assert property (@(posedge clk) disable iff (rst) out_valid |=> !out_valid)
        else $error("out_valid held high for two cycles");

    a_pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready dropped low");

    a_idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !running)
        else $error("running high in the first cycle after reset");

endmodule

`default_nettype wire

// ==== tb/cpu_checker.sv ====
// output stream checker
`timescale 1ns/1ps
`default_nettype none

module cpu_checker import cpu_pkg::*; (
    input wire              clk,
    input wire              rst,
    input wire              out_valid,
    input wire [WORD_W-1:0] out_data
);

    logic [WORD_W-1:0] exp_q [$];
    logic [WORD_W-1:0] exp_w;
    int stream_err = 0;
    int check_err = 0;

    function void push_expected(input logic [WORD_W-1:0] w);
        exp_q.push_back(w);
    endfunction

    function int pending();
        return exp_q.size();
    endfunction

    function void clear_expected();
        exp_q.delete();
    endfunction

    function int errors();
        return stream_err + check_err;
    endfunction

    function void check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h got %h", name, expected, actual);
            check_err++;
        end
    endfunction

    function void report_problem(input string msg);
        $display("%s", msg);
        check_err++;
    endfunction

    // stream outputs settle after the rising edge
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("output word %h arrived while no word was expected", out_data);
                stream_err++;
            end else begin
                exp_w = exp_q.pop_front();
                if (exp_w !== out_data) begin
                    $display("FAIL out_data expected %h got %h", exp_w, out_data);
                    stream_err++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/cpu_tb.sv ====
// cpu subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int MEM_AW = 8;
    localparam int MEM_WORDS = 2**MEM_AW;
    // instructions executed over all runs at up to 5 cycles each
    localparam int PROG_TOTAL = 78;
    localparam int NUM_TESTS = 6;
    localparam int CYCLE_LIMIT = 5 * PROG_TOTAL + 200 * NUM_TESTS;

    logic              clk;
    logic              rst;
    logic [7:0]        paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic [WORD_W-1:0] out_data;
    logic              out_valid;

    logic [WORD_W-1:0] mem_img [MEM_WORDS];
    logic [REG_W-1:0]  model_regs [16];
    logic [WORD_W-1:0] prog_q [$];
    logic [31:0]       rd_val;
    logic [31:0]       rnd;
    int cycle_cnt = 0;
    int tests_failed = 0;
    int err_mark = 0;
    int exp_cnt;
    int op;
    int imm;

    cpu_top #(.MEM_AW(MEM_AW)) i_dut (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .out_data(out_data), .out_valid(out_valid)
    );

    cpu_checker i_chk (.clk(clk), .rst(rst), .out_valid(out_valid), .out_data(out_data));

    bind cpu_top cpu_props i_props (
        .clk(clk), .rst(rst), .pready(pready), .out_valid(out_valid), .running(running)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: test sequence still running after %0d cycles", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [WORD_W-1:0] instr(input int rsel, input int opc, input int val);
        return {4'(rsel), 4'(opc), 8'(val)};
    endfunction

    // reference model walks the memory image from address 0 until HALT
    function automatic int ref_run();
        int pc;
        int steps;
        int count;
        logic done;
        logic [WORD_W-1:0] w;
        pc = 0;
        steps = 0;
        count = 0;
        done = 1'b0;
        while (!done && steps < 4 * MEM_WORDS) begin
            w = mem_img[pc];
            steps++;
            case (w[11:8])
                OP_OUTI: begin
                    i_chk.push_expected({8'h00, w[7:0]});
                    count++;
                end
                OP_OUTLOC: begin
                    // immediate shifted right by one and cut to the memory size
                    i_chk.push_expected(mem_img[int'(w[7:1]) % MEM_WORDS]);
                    count++;
                end
                OP_LI: model_regs[w[15:12]] = w[7:0];
                OP_OUTR: begin
                    i_chk.push_expected({8'h00, model_regs[w[15:12]]});
                    count++;
                end
                OP_HALT: done = 1'b1;
                default: ;
            endcase
            pc = (pc + 1) % MEM_WORDS;
        end
        if (!done) begin
            i_chk.report_problem("reference model never reached a HALT instruction");
        end
        return count;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            input logic exp_err, output logic [31:0] rdata);
        @(negedge clk);
        paddr = addr;
        pwdata = data;
        pwrite = wr;
        psel = 1'b1;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        i_chk.check_value($sformatf("pslverr at %h", addr), {31'd0, exp_err}, {31'd0, pslverr});
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_check(input logic [7:0] addr, input string name,
                              input logic [31:0] expected);
        logic [31:0] val;
        apb_xfer(1'b0, addr, 32'd0, 1'b0, val);
        i_chk.check_value(name, expected, val);
    endtask

    task automatic load_prog(input int base);
        apb_xfer(1'b1, REG_LD_ADDR, 32'(base), 1'b0, rd_val);
        foreach (prog_q[i]) begin
            apb_xfer(1'b1, REG_LD_DATA, {16'h0000, prog_q[i]}, 1'b0, rd_val);
            mem_img[(base + i) % MEM_WORDS] = prog_q[i];
        end
    endtask

    task automatic start_run();
        exp_cnt = ref_run();
        apb_xfer(1'b1, REG_CTRL, 32'd1, 1'b0, rd_val);
    endtask

    task automatic end_run();
        rd_val = '0;
        while (!rd_val[1]) begin
            apb_xfer(1'b0, REG_STATUS, 32'd0, 1'b0, rd_val);
        end
        if (i_chk.pending() != 0) begin
            i_chk.report_problem($sformatf("%0d expected output words never appeared",
                                           i_chk.pending()));
            i_chk.clear_expected();
        end
        read_check(REG_OUT_CNT, "prdata OUT_CNT", 32'(exp_cnt));
    endtask

    task automatic close_test(input int num, input string name);
        if (i_chk.errors() == err_mark) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, i_chk.errors() - err_mark);
        end
        err_mark = i_chk.errors();
    endtask

    initial begin
        rst = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        void'($urandom(32'h1c08_f183));
        for (int r = 0; r < 16; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        read_check(REG_STATUS, "prdata STATUS", 32'd0);
        read_check(REG_OUT_CNT, "prdata OUT_CNT", 32'd0);
        apb_xfer(1'b0, 8'h14, 32'd0, 1'b1, rd_val);
        apb_xfer(1'b1, 8'h20, 32'h5a5a, 1'b1, rd_val);
        close_test(1, "reset values and unmapped offset");

        prog_q = {instr(0, OP_OUTI, 'h11), instr(0, OP_OUTI, 'h22), instr(3, OP_OUTI, 'hff),
                  instr(0, OP_OUTI, 'h00), instr(9, OP_OUTI, 'h5a), instr(0, OP_HALT, 0)};
        load_prog(0);
        start_run();
        end_run();
        close_test(2, "immediate stream");

        // register 7 is written three times
        prog_q = {instr(0, OP_LI, 'h12), instr(7, OP_LI, 'h7e), instr(15, OP_LI, 'hf0),
                  instr(7, OP_OUTR, 0), instr(7, OP_LI, 'h81), instr(7, OP_LI, 'ha5),
                  instr(0, OP_OUTR, 0), instr(7, OP_OUTR, 0), instr(15, OP_OUTR, 0),
                  instr(0, OP_HALT, 0)};
        load_prog(0);
        start_run();
        end_run();
        close_test(3, "register load and emit");

        prog_q = {instr(0, OP_OUTLOC, 'h20), instr(0, OP_OUTLOC, 'h23),
                  instr(0, OP_OUTLOC, 'h27), instr(0, OP_HALT, 0)};
        load_prog(0);
        prog_q = {16'hbeef, 16'h1234, 16'h8001, 16'hffff};
        load_prog(16);
        start_run();
        end_run();
        close_test(4, "memory word emit");

        prog_q.delete();
        for (int i = 0; i < 39; i++) begin
            rnd = $urandom;
            case (rnd[31:16] % 6)
                0: op = OP_NOP;
                1: op = OP_OUTI;
                2: op = OP_OUTLOC;
                3: op = OP_LI;
                4: op = OP_OUTR;
                default: op = 5 + int'(rnd[15:12] % 10);
            endcase
            // data words for OUTLOC sit at 64 to 79
            imm = (op == OP_OUTLOC) ? 'h80 + int'(rnd[4:0]) : int'(rnd[7:0]);
            prog_q.push_back(instr(int'(rnd[11:8]), op, imm));
        end
        prog_q.push_back(instr(0, OP_HALT, 0));
        load_prog(0);
        prog_q.delete();
        for (int a = 64; a < 80; a++) begin
            prog_q.push_back({8'(a) ^ 8'h3c, 8'(a * 7)});
        end
        load_prog(64);
        start_run();
        end_run();
        close_test(5, "random program");

        prog_q.delete();
        for (int i = 0; i < 8; i++) begin
            prog_q.push_back(instr(i, OP_OUTI, 'h90 + i));
        end
        prog_q.push_back(instr(0, OP_HALT, 0));
        load_prog(0);
        // load pointer parked on the first instruction of the program
        apb_xfer(1'b1, REG_LD_ADDR, 32'd0, 1'b0, rd_val);
        start_run();
        apb_xfer(1'b1, REG_LD_ADDR, 32'd5, 1'b1, rd_val);
        apb_xfer(1'b1, REG_LD_DATA, {16'h0000, instr(0, OP_HALT, 0)}, 1'b1, rd_val);
        end_run();
        read_check(REG_STATUS, "prdata STATUS", 32'd2);
        read_check(REG_LD_ADDR, "prdata LD_ADDR", 32'd0);
        start_run();
        end_run();
        close_test(6, "load during run and restart");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 NUM_TESTS, tests_failed, i_chk.errors());
        if (i_chk.errors() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/cpu_pkg.sv
rtl/cpu_regfile.sv
rtl/prog_mem.sv
rtl/cpu_core.sv
rtl/cpu_ctrl_regs.sv
rtl/cpu_top.sv
tb/cpu_props.sv
tb/cpu_checker.sv
tb/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -f all.f -o sim_cpu
./obj_dir/sim_cpu | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
